// ==== sources.f ====
design/oob_bus_pkg.sv
design/odc_cfg_pkg.sv
design/cmd_fifo.sv
design/cmd_prefetch.sv
design/oob_packet_gen.sv
design/oob_downstream_cntl.sv
verif/tb_oob_downstream_cntl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the OOB downstream controller regression with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_oob_downstream_cntl -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$LOG"; then
  exit 0
fi
exit 1

// ==== verif/tb_oob_downstream_cntl.sv ====
// OOB downstream controller testbench
`timescale 1ns/10ps

module tb_oob_downstream_cntl;

  localparam int unsigned SEED = 32'hceaa6add;
  localparam int NUM_BURST    = 40;
  localparam int NUM_BP       = 12;
  localparam int NUM_ERR      = 10;
  localparam int STALL_CYCLES = 30;
  // Four cycles per command including the malformed and recovery ones
  localparam int TIMEOUT_CYCLES = (NUM_BURST + NUM_BP + NUM_ERR + 2) * 4
                                  + STALL_CYCLES + 200;

  logic                   clk;
  logic                   reset;
  logic                   cmd_valid;
  odc_cfg_pkg::odc_cmd_t  cmd;
  logic                   cmd_ready;
  logic                   oob_valid;
  oob_bus_pkg::oob_beat_t oob_beat;
  logic                   oob_ready;

  odc_cfg_pkg::odc_cmd_t exp_q[$];
  string                 test_name = "reset";
  int                    value_errors = 0;
  int                    protocol_errors = 0;
  int                    cycles = 0;
  int                    low_cycles = 0;
  bit                    in_pkt = 1'b0;
  bit                    locked = 1'b0;
  bit                    saw_backpressure = 1'b0;

  oob_downstream_cntl uut (
    .clk       (clk),
    .reset     (reset),
    .cmd_valid (cmd_valid),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .oob_valid (oob_valid),
    .oob_beat  (oob_beat),
    .oob_ready (oob_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic odc_cfg_pkg::odc_cmd_t random_cmd(oob_bus_pkg::std_cntl_t cntl);
    odc_cfg_pkg::odc_cmd_t c;
    c.cntl      = cntl;
    c.tag       = odc_cfg_pkg::tag_t'($urandom);
    c.num_lanes = odc_cfg_pkg::num_lanes_t'($urandom);
    c.stop_cmd  = odc_cfg_pkg::op_cmd_t'($urandom);
    c.simd_cmd  = odc_cfg_pkg::op_cmd_t'($urandom);
    return c;
  endfunction

  // Expected beat for either half of a packet
  function automatic oob_bus_pkg::oob_beat_t packet_beat(odc_cfg_pkg::odc_cmd_t c, bit second);
    oob_bus_pkg::oob_beat_t b;
    b.pkt_type = oob_bus_pkg::OOB_TYPE_PE_OP_CMD;
    if (!second)
    begin
      b.cntl         = oob_bus_pkg::CNTL_SOM;
      b.data.option0 = oob_bus_pkg::OOB_OPT_STOP_CMD;
      b.data.value0  = c.stop_cmd;
      b.data.option1 = oob_bus_pkg::OOB_OPT_SIMD_CMD;
      b.data.value1  = c.simd_cmd;
    end
    else
    begin
      b.cntl         = oob_bus_pkg::CNTL_EOM;
      b.data.option0 = oob_bus_pkg::OOB_OPT_TAG;
      b.data.value0  = c.tag;
      b.data.option1 = oob_bus_pkg::OOB_OPT_NUM_LANES;
      b.data.value1  = {2'b00, c.num_lanes};
    end
    return b;
  endfunction

  task automatic protocol_fail(string what);
    protocol_errors++;
    $display("Error in %s at %0t: %s", test_name, $time, what);
  endtask

  task automatic compare_beat(oob_bus_pkg::oob_beat_t expected);
    assert (oob_beat == expected)
    else
    begin
      value_errors++;
      $display("[ERROR] %s: beat expected %h actual %h", test_name, expected, oob_beat);
    end
  endtask

  task automatic reset_dut();
    reset     = 1'b1;
    cmd_valid = 1'b0;
    repeat (4)
    begin
      @(negedge clk);
      assert (!cmd_ready && !oob_valid) else protocol_fail("outputs not low during reset");
      compare_beat('0);
    end
    reset = 1'b0;
    repeat (5)
    begin
      if (!cmd_ready)
        @(negedge clk);
    end
    assert (cmd_ready) else protocol_fail("cmd_ready did not rise after reset");
  endtask

  // One decoder command per valid cycle
  task automatic send_cmd(odc_cfg_pkg::odc_cmd_t c, bit expect_pkt);
    while (!cmd_ready)
    begin
      saw_backpressure = 1'b1;
      @(negedge clk);
    end
    cmd_valid = 1'b1;
    cmd       = c;
    if (expect_pkt)
      exp_q.push_back(c);
    @(negedge clk);
    cmd_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  // --------------------------------------------------------------------------
  // Checkers
  // --------------------------------------------------------------------------
  som_then_eom: assert property (@(posedge clk) disable iff (reset)
    (oob_valid && oob_beat.cntl == oob_bus_pkg::CNTL_SOM) |=>
    (oob_valid && oob_beat.cntl == oob_bus_pkg::CNTL_EOM))
    else protocol_fail("EOM beat missing after a SOM beat");

  // Cycles the bus has been stalled
  always @(posedge clk)
  begin
    if (reset || oob_ready)
      low_cycles <= 0;
    else
      low_cycles <= low_cycles + 1;
  end

  // Scoreboard on the falling edge
  always @(negedge clk)
  begin
    if (reset)
      in_pkt = 1'b0;
    else if (oob_valid && oob_beat.cntl == oob_bus_pkg::CNTL_SOM)
    begin
      assert (!in_pkt) else protocol_fail("SOM beat inside a packet");
      assert (!locked) else protocol_fail("packet sent after the error latch");
      assert (low_cycles < 3) else protocol_fail("SOM beat while oob_ready was low");
      assert (exp_q.size() != 0) else protocol_fail("packet with no command pending");
      if (exp_q.size() != 0)
        compare_beat(packet_beat(exp_q[0], 1'b0));
      in_pkt = 1'b1;
    end
    else if (oob_valid && oob_beat.cntl == oob_bus_pkg::CNTL_EOM && in_pkt)
    begin
      if (exp_q.size() != 0)
      begin
        compare_beat(packet_beat(exp_q[0], 1'b1));
        void'(exp_q.pop_front());
      end
      in_pkt = 1'b0;
    end
    else
    begin
      assert (!oob_valid) else protocol_fail("oob_valid high outside a packet");
      assert (!in_pkt) else protocol_fail("SOM beat not followed by an EOM beat");
      in_pkt = 1'b0;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  initial
  begin
    void'($urandom(SEED));
    reset     = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    oob_ready = 1'b1;
    reset_dut();

    test_name = "burst";
    repeat (NUM_BURST) send_cmd(random_cmd(oob_bus_pkg::CNTL_SOM_EOM), 1'b1);
    wait_drain();

    // Bus stalls a few cycles into the stream
    test_name        = "backpressure";
    saw_backpressure = 1'b0;
    fork
      begin
        repeat (4) @(negedge clk);
        oob_ready = 1'b0;
        repeat (STALL_CYCLES) @(negedge clk);
        oob_ready = 1'b1;
      end
      repeat (NUM_BP) send_cmd(random_cmd(oob_bus_pkg::CNTL_SOM_EOM), 1'b1);
    join
    assert (saw_backpressure) else protocol_fail("cmd_ready never fell during the stall");
    wait_drain();

    // Malformed framing locks all output
    test_name = "error_latch";
    locked    = 1'b1;
    send_cmd(random_cmd(oob_bus_pkg::CNTL_SOM), 1'b0);
    for (int i = 0; i < NUM_ERR; i++)
    begin
      if (cmd_ready)
        send_cmd(random_cmd(oob_bus_pkg::CNTL_SOM_EOM), 1'b0);
    end
    repeat (4) @(negedge clk);
    assert (!cmd_ready) else protocol_fail("cmd_ready stayed high after the error latch");

    test_name = "recovery";
    reset_dut();
    locked = 1'b0;
    send_cmd(random_cmd(oob_bus_pkg::CNTL_SOM_EOM), 1'b1);
    wait_drain();

    $display("Errors: %0d value, %0d protocol, %0d commands unmatched",
             value_errors, protocol_errors, exp_q.size());
    if (value_errors == 0 && protocol_errors == 0 && exp_q.size() == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== design/oob_downstream_cntl.sv ====
// OOB downstream controller top
`timescale 1ns/10ps

module oob_downstream_cntl (
  input  logic                   clk,
  input  logic                   reset,
  // From the work-unit decoder
  input  logic                   cmd_valid,
  input  odc_cfg_pkg::odc_cmd_t  cmd,
  output logic                   cmd_ready,
  // Stack bus OOB downstream
  output logic                   oob_valid,
  output oob_bus_pkg::oob_beat_t oob_beat,
  input  logic                   oob_ready
);

  logic                  cmd_valid_q;
  odc_cfg_pkg::odc_cmd_t cmd_q;
  logic                  oob_ready_q;

  logic                  fifo_rd;
  logic                  fifo_empty;
  logic                  fifo_almost_full;
  odc_cfg_pkg::odc_cmd_t fifo_rd_data;

  logic                  head_valid;
  odc_cfg_pkg::odc_cmd_t head_cmd;
  logic                  head_pop;

  // --------------------------------------------------------------------------
  // Boundary registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cmd_valid_q <= 1'b0;
      cmd_ready   <= 1'b0;
      oob_ready_q <= 1'b0;
    end
    else
    begin
      cmd_valid_q <= cmd_valid;
      cmd_ready   <= ~fifo_almost_full;
      oob_ready_q <= oob_ready;
    end
  end

  always_ff @(posedge clk)
  begin
    cmd_q <= cmd;
  end

  // --------------------------------------------------------------------------
  // Command path
  // --------------------------------------------------------------------------
  cmd_fifo u_cmd_fifo (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (cmd_valid_q),
    .wr_data     (cmd_q),
    .rd_en       (fifo_rd),
    .rd_data     (fifo_rd_data),
    .empty       (fifo_empty),
    .almost_full (fifo_almost_full)
  );

  cmd_prefetch u_cmd_prefetch (
    .clk        (clk),
    .reset      (reset),
    .fifo_empty (fifo_empty),
    .fifo_data  (fifo_rd_data),
    .fifo_rd    (fifo_rd),
    .head_valid (head_valid),
    .head_cmd   (head_cmd),
    .head_pop   (head_pop)
  );

  oob_packet_gen u_oob_packet_gen (
    .clk        (clk),
    .reset      (reset),
    .head_valid (head_valid),
    .head_cmd   (head_cmd),
    .head_pop   (head_pop),
    .bus_ready  (oob_ready_q),
    .oob_valid  (oob_valid),
    .oob_beat   (oob_beat)
  );

endmodule

// ==== design/oob_packet_gen.sv ====
// OOB downstream packet generator
`timescale 1ns/10ps

module oob_packet_gen (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   head_valid,
  input  odc_cfg_pkg::odc_cmd_t  head_cmd,
  output logic                   head_pop,
  input  logic                   bus_ready,
  output logic                   oob_valid,
  output oob_bus_pkg::oob_beat_t oob_beat
);

  odc_cfg_pkg::odc_state_t state;
  odc_cfg_pkg::odc_state_t state_next;
  oob_bus_pkg::oob_beat_t  beat_next;
  logic                    valid_next;

  // --------------------------------------------------------------------------
  // State machine
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      state <= odc_cfg_pkg::WAIT;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      odc_cfg_pkg::WAIT:
      begin
        // Only single-beat commands are expected from the decoder
        if (head_valid && bus_ready)
          state_next = (head_cmd.cntl == oob_bus_pkg::CNTL_SOM_EOM) ?
                       odc_cfg_pkg::START_PKT : odc_cfg_pkg::ERR;
      end
      odc_cfg_pkg::START_PKT:   state_next = odc_cfg_pkg::SECOND_BEAT;
      odc_cfg_pkg::SECOND_BEAT: state_next = odc_cfg_pkg::WAIT;
      // Locked until reset
      odc_cfg_pkg::ERR:         state_next = odc_cfg_pkg::ERR;
      default:                  state_next = odc_cfg_pkg::WAIT;
    endcase
  end

  // Head is consumed after the last beat is encoded
  assign head_pop = (state == odc_cfg_pkg::SECOND_BEAT);

  // --------------------------------------------------------------------------
  // Beat encoding
  // --------------------------------------------------------------------------
  always_comb
  begin
    valid_next             = 1'b0;
    beat_next.cntl         = oob_bus_pkg::CNTL_MOM;
    beat_next.pkt_type     = oob_bus_pkg::OOB_TYPE_NA;
    beat_next.data.option0 = oob_bus_pkg::OOB_OPT_NOP;
    beat_next.data.value0  = '0;
    beat_next.data.option1 = oob_bus_pkg::OOB_OPT_NOP;
    beat_next.data.value1  = '0;
    if (state == odc_cfg_pkg::START_PKT)
    begin
      valid_next             = 1'b1;
      beat_next.cntl         = oob_bus_pkg::CNTL_SOM;
      beat_next.pkt_type     = oob_bus_pkg::OOB_TYPE_PE_OP_CMD;
      beat_next.data.option0 = oob_bus_pkg::OOB_OPT_STOP_CMD;
      beat_next.data.value0  = head_cmd.stop_cmd;
      beat_next.data.option1 = oob_bus_pkg::OOB_OPT_SIMD_CMD;
      beat_next.data.value1  = head_cmd.simd_cmd;
    end
    else if (state == odc_cfg_pkg::SECOND_BEAT)
    begin
      valid_next             = 1'b1;
      beat_next.cntl         = oob_bus_pkg::CNTL_EOM;
      beat_next.pkt_type     = oob_bus_pkg::OOB_TYPE_PE_OP_CMD;
      beat_next.data.option0 = oob_bus_pkg::OOB_OPT_TAG;
      beat_next.data.value0  = head_cmd.tag;
      beat_next.data.option1 = oob_bus_pkg::OOB_OPT_NUM_LANES;
      beat_next.data.value1  = oob_bus_pkg::oob_value_t'(head_cmd.num_lanes);
    end
  end

  // Registered bus outputs, one cycle behind the state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      oob_valid <= 1'b0;
      oob_beat  <= '0;
    end
    else
    begin
      oob_valid <= valid_next;
      oob_beat  <= beat_next;
    end
  end

endmodule

// ==== design/cmd_prefetch.sv ====
// Two-stage command prefetch
`timescale 1ns/10ps

module cmd_prefetch (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fifo_empty,
  input  odc_cfg_pkg::odc_cmd_t fifo_data,
  output logic                  fifo_rd,
  output logic                  head_valid,
  output odc_cfg_pkg::odc_cmd_t head_cmd,
  input  logic                  head_pop
);

  // FIFO read register is the first stage; this flag says it holds a command
  logic fifo_stage_valid;
  logic fifo_stage_move;

  // Move the FIFO output forward when the head is free or leaving
  assign fifo_stage_move = fifo_stage_valid & (~head_valid | head_pop);

  // Keep the pipe charged
  assign fifo_rd = ~fifo_empty & (~fifo_stage_valid | fifo_stage_move);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      fifo_stage_valid <= 1'b0;
      head_valid       <= 1'b0;
    end
    else
    begin
      if (fifo_rd)
        fifo_stage_valid <= 1'b1;
      else if (fifo_stage_move)
        fifo_stage_valid <= 1'b0;

      if (fifo_stage_move)
        head_valid <= 1'b1;
      else if (head_pop)
        head_valid <= 1'b0;
    end
  end

  // Head copy of the command
  always_ff @(posedge clk)
  begin
    if (fifo_stage_move)
      head_cmd <= fifo_data;
  end

endmodule

// ==== design/cmd_fifo.sv ====
// Decoder command FIFO
`timescale 1ns/10ps

module cmd_fifo (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wr_en,
  input  odc_cfg_pkg::odc_cmd_t wr_data,
  input  logic                 rd_en,
  output odc_cfg_pkg::odc_cmd_t rd_data,
  output logic                 empty,
  output logic                 almost_full
);

  odc_cfg_pkg::odc_cmd_t mem [odc_cfg_pkg::CMD_FIFO_DEPTH];

  logic [odc_cfg_pkg::CMD_FIFO_ADDR_W-1:0] wr_ptr;
  logic [odc_cfg_pkg::CMD_FIFO_ADDR_W-1:0] rd_ptr;
  // One extra bit so a full FIFO is distinct from an empty one
  logic [odc_cfg_pkg::CMD_FIFO_ADDR_W:0]   count;
  logic                                    full;
  logic                                    do_wr;
  logic                                    do_rd;

  assign full  = (count == odc_cfg_pkg::CMD_FIFO_DEPTH);
  assign empty = (count == '0);
  assign do_wr = wr_en & ~full;
  assign do_rd = rd_en & ~empty;

  // Almost full once free entries drop to the threshold
  assign almost_full = (count >= (odc_cfg_pkg::CMD_FIFO_DEPTH - odc_cfg_pkg::CMD_FIFO_THRESHOLD));

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous read and write leaves the count alone
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

  // Storage and registered read port
  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
    if (do_rd)
      rd_data <= mem[rd_ptr];
  end

endmodule

// ==== design/odc_cfg_pkg.sv ====
// OOB downstream controller configuration
package odc_cfg_pkg;

  // --------------------------------------------------------------------------
  // Command fields from the work-unit decoder
  // --------------------------------------------------------------------------
  typedef logic [7:0] tag_t;
  typedef logic [5:0] num_lanes_t;
  typedef logic [7:0] op_cmd_t;

  // Single-beat decoder command, 32 bits
  typedef struct packed {
    oob_bus_pkg::std_cntl_t cntl;
    tag_t                   tag;
    num_lanes_t             num_lanes;
    op_cmd_t                stop_cmd;
    op_cmd_t                simd_cmd;
  } odc_cmd_t;

  // --------------------------------------------------------------------------
  // Command FIFO sizing
  // --------------------------------------------------------------------------
  localparam int CMD_FIFO_DEPTH  = 8;
  localparam int CMD_FIFO_ADDR_W = 3;
  // Free entries left when almost-full rises; covers the ready and input flops
  localparam int CMD_FIFO_THRESHOLD = 3;

  // --------------------------------------------------------------------------
  // Packet generator states
  // --------------------------------------------------------------------------
  typedef enum logic [1:0] {
    WAIT        = 2'd0,
    START_PKT   = 2'd1,
    SECOND_BEAT = 2'd2,
    ERR         = 2'd3
  } odc_state_t;

endpackage

// ==== design/oob_bus_pkg.sv ====
// Stack bus OOB definitions
package oob_bus_pkg;

  // --------------------------------------------------------------------------
  // Framing codes shared by all standard interfaces
  // --------------------------------------------------------------------------
  typedef logic [1:0] std_cntl_t;

  localparam std_cntl_t CNTL_SOM_EOM = 2'd0;
  localparam std_cntl_t CNTL_SOM     = 2'd1;
  localparam std_cntl_t CNTL_MOM     = 2'd2;
  localparam std_cntl_t CNTL_EOM     = 2'd3;

  // --------------------------------------------------------------------------
  // OOB packet fields
  // --------------------------------------------------------------------------
  typedef logic [1:0] oob_type_t;
  typedef logic [3:0] oob_option_t;
  typedef logic [7:0] oob_value_t;

  // Packet types
  localparam oob_type_t OOB_TYPE_NA        = 2'd0;
  localparam oob_type_t OOB_TYPE_PE_OP_CMD = 2'd1;

  // Option codes carried in each option slot
  localparam oob_option_t OOB_OPT_NOP       = 4'd0;
  localparam oob_option_t OOB_OPT_STOP_CMD  = 4'd1;
  localparam oob_option_t OOB_OPT_SIMD_CMD  = 4'd2;
  localparam oob_option_t OOB_OPT_TAG       = 4'd3;
  localparam oob_option_t OOB_OPT_NUM_LANES = 4'd4;

  // Two option/value pairs per beat
  typedef struct packed {
    oob_option_t option0;
    oob_value_t  value0;
    oob_option_t option1;
    oob_value_t  value1;
  } oob_data_t;

  // One downstream beat, 28 bits
  typedef struct packed {
    std_cntl_t cntl;
    oob_type_t pkt_type;
    oob_data_t data;
  } oob_beat_t;

endpackage
